/* include/mr_ddr_params.svh */
// DDR port widths, pixel packing, frame buffer base and load length width
`ifndef MR_DDR_PARAMS_SVH
`define MR_DDR_PARAMS_SVH

// DDR word address and data widths
`define DDR_AW          29
`define DDR_DW          64
`define BYTES_PER_WORD  8

// Rotation pixels, four per DDR word
`define PIX_W           16
`define PIX_PER_WORD    4

// First word of the rotation frame buffer
`define ROT_BASE        29'h0100000

// Load length counts DDR words
`define LOAD_LEN_W      16

`endif

/* hdl/mr_ddr_pkg.sv */
// DDR address, pixel and DDR word types shared by the bridge
`include "mr_ddr_params.svh"

package mr_ddr_pkg;

    // Word address on the DDR port
    typedef logic [`DDR_AW-1:0] ddr_addr_t;

    // One rotation pixel
    typedef logic [`PIX_W-1:0] pixel_t;

    // One DDR word, seen as bytes by the loader and as pixels by the writer
    // Element 0 sits in the low bits in both views
    typedef union packed {
        logic [`DDR_DW/8-1:0][7:0]         bytes;
        pixel_t [`PIX_PER_WORD-1:0]        pixels;
    } ddr_word_t;

endpackage

/* hdl/ddr_load_reader.sv */
// Fast-load reader: one DDR word per grant, unpacked into ioctl byte writes
`timescale 1ns/1ps
`include "mr_ddr_params.svh"

module ddr_load_reader (
    input  logic                   clk_sys,
    input  logic                   rst,
    // Load command
    input  logic                   load_req,
    input  mr_ddr_pkg::ddr_addr_t  load_addr,
    input  logic [`LOAD_LEN_W-1:0] load_len,
    output logic                   load_ack,
    // Arbiter handshake
    output logic                   arb_req,
    input  logic                   arb_ack,
    // DDR side
    input  logic                   busy,
    output logic                   rd,
    output mr_ddr_pkg::ddr_addr_t  addr,
    input  mr_ddr_pkg::ddr_word_t  dout,
    input  logic                   dout_ready,
    // Byte stream
    output logic                   ioctl_wr,
    output logic [26:0]            ioctl_addr,
    output logic [7:0]             ioctl_dout
);

    localparam int BYTE_W = $clog2(`BYTES_PER_WORD);
    localparam logic [BYTE_W-1:0] LAST_BYTE = BYTE_W'(`BYTES_PER_WORD - 1);

    localparam logic [2:0] ST_IDLE  = 3'd0;
    localparam logic [2:0] ST_REQ   = 3'd1;
    localparam logic [2:0] ST_RD    = 3'd2;
    localparam logic [2:0] ST_WAIT  = 3'd3;
    localparam logic [2:0] ST_SHIFT = 3'd4;
    localparam logic [2:0] ST_DONE  = 3'd5;

    logic [2:0]             state;
    logic [`LOAD_LEN_W-1:0] word_cnt;
    logic [BYTE_W-1:0]      byte_cnt;
    logic [26:0]            byte_addr;
    mr_ddr_pkg::ddr_word_t  word;
    logic                   accepted;

    assign accepted = (state == ST_RD) && !busy;

    // Bytes leave straight from the latched word, one per SHIFT cycle
    assign rd         = (state == ST_RD);
    assign ioctl_wr   = (state == ST_SHIFT);
    assign ioctl_addr = byte_addr;
    assign ioctl_dout = word.bytes[byte_cnt];

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            state     <= ST_IDLE;
            load_ack  <= 1'b0;
            arb_req   <= 1'b0;
            word_cnt  <= '0;
            byte_cnt  <= '0;
            byte_addr <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    word_cnt  <= '0;
                    byte_cnt  <= '0;
                    byte_addr <= '0;
                    if (load_req) begin
                        if (load_len == '0) begin
                            // Empty load, acknowledge at once
                            load_ack <= 1'b1;
                            state    <= ST_DONE;
                        end else begin
                            arb_req <= 1'b1;
                            state   <= ST_REQ;
                        end
                    end
                end
                ST_REQ: begin
                    if (arb_ack) state <= ST_RD;
                end
                ST_RD: begin
                    // One access per grant, so release as soon as the read is taken
                    if (accepted) begin
                        arb_req <= 1'b0;
                        state   <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (dout_ready) begin
                        word_cnt <= word_cnt + 1'b1;
                        byte_cnt <= '0;
                        state    <= ST_SHIFT;
                    end
                end
                ST_SHIFT: begin
                    byte_cnt  <= byte_cnt + 1'b1;
                    byte_addr <= byte_addr + 1'b1;
                    if (byte_cnt == LAST_BYTE) begin
                        if (word_cnt == load_len) begin
                            load_ack <= 1'b1;
                            state    <= ST_DONE;
                        end else begin
                            arb_req <= 1'b1;
                            state   <= ST_REQ;
                        end
                    end
                end
                ST_DONE: begin
                    if (!load_req) begin
                        load_ack <= 1'b0;
                        state    <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Read address and returned data
    always_ff @(posedge clk_sys) begin
        if (state == ST_IDLE) begin
            addr <= load_addr;
        end else if (accepted) begin
            addr <= addr + 1'b1;
        end
        if (state == ST_WAIT && dout_ready) begin
            word <= dout;
        end
    end

    ap_wr_in_load: assert property (@(posedge clk_sys) disable iff (rst)
        ioctl_wr |-> load_req);

    ap_rd_granted: assert property (@(posedge clk_sys) disable iff (rst)
        rd |-> arb_ack);

endmodule

/* hdl/rot_line_writer.sv */
// Rotation line writer: packs pixels into DDR words for the frame buffer
`timescale 1ns/1ps
`include "mr_ddr_params.svh"

module rot_line_writer (
    input  logic                  clk_sys,
    input  logic                  rst,
    // Pixel stream
    input  logic                  pix_valid,
    input  logic                  pix_sof,
    input  mr_ddr_pkg::pixel_t    pix_data,
    output logic                  pix_ready,
    // Arbiter handshake
    output logic                  arb_req,
    input  logic                  arb_ack,
    // DDR side
    input  logic                  busy,
    output logic                  we,
    output mr_ddr_pkg::ddr_addr_t addr,
    output mr_ddr_pkg::ddr_word_t din
);

    localparam int SLOT_W = $clog2(`PIX_PER_WORD);
    localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(`PIX_PER_WORD - 1);

    logic [SLOT_W-1:0]     slot;
    logic [SLOT_W-1:0]     slot_idx;
    mr_ddr_pkg::ddr_word_t word;
    logic                  xfer;
    logic                  accept;

    assign xfer   = pix_valid && pix_ready;
    // Start of frame always lands in slot 0
    assign slot_idx = pix_sof ? '0 : slot;

    // arb_req doubles as the write pending flag
    assign we     = arb_req && arb_ack;
    assign accept = we && !busy;
    assign din    = word;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            pix_ready <= 1'b1;
            arb_req   <= 1'b0;
            slot      <= '0;
            addr      <= `ROT_BASE;
        end else begin
            if (xfer) begin
                slot <= slot_idx + 1'b1;
                if (pix_sof) begin
                    addr <= `ROT_BASE;
                end
                if (slot_idx == LAST_SLOT) begin
                    // Word complete, hold the stream until it is written
                    pix_ready <= 1'b0;
                    arb_req   <= 1'b1;
                end
            end
            if (accept) begin
                pix_ready <= 1'b1;
                arb_req   <= 1'b0;
                addr      <= addr + 1'b1;
            end
        end
    end

    // Pixel k of a word goes to bits 16k+15 down to 16k
    always_ff @(posedge clk_sys) begin
        if (xfer) begin
            word.pixels[slot_idx] <= pix_data;
        end
    end

    // A stalled write keeps its grant, address and data with the stream held
    ap_write_held: assert property (@(posedge clk_sys) disable iff (rst)
        we && busy |=> we && !pix_ready && $stable(addr) && $stable(din));

endmodule

/* hdl/ddr_client_arbiter.sv */
// Two-client DDR arbiter with req/ack grants and a combinational port mux
`timescale 1ns/1ps

module ddr_client_arbiter (
    input  logic                  clk_sys,
    input  logic                  rst,
    // Loader client
    input  logic                  load_arb_req,
    output logic                  load_arb_ack,
    input  logic                  load_rd,
    input  mr_ddr_pkg::ddr_addr_t load_addr,
    output logic                  load_busy,
    // Rotation client
    input  logic                  rot_arb_req,
    output logic                  rot_arb_ack,
    input  logic                  rot_we,
    input  mr_ddr_pkg::ddr_addr_t rot_addr,
    input  mr_ddr_pkg::ddr_word_t rot_din,
    output logic                  rot_busy,
    // DDR port
    input  logic                  ddr_busy,
    output logic                  ddr_rd,
    output logic                  ddr_we,
    output mr_ddr_pkg::ddr_addr_t ddr_addr,
    output mr_ddr_pkg::ddr_word_t ddr_din
);

    localparam logic [1:0] GNT_IDLE = 2'd0;
    localparam logic [1:0] GNT_LOAD = 2'd1;
    localparam logic [1:0] GNT_ROT  = 2'd2;

    logic [1:0] grant;

    // Grant held until the owner drops its request
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            grant <= GNT_IDLE;
        end else begin
            case (grant)
                GNT_IDLE: begin
                    // Loader has priority
                    if (load_arb_req) begin
                        grant <= GNT_LOAD;
                    end else if (rot_arb_req) begin
                        grant <= GNT_ROT;
                    end
                end
                GNT_LOAD: begin
                    if (!load_arb_req) grant <= GNT_IDLE;
                end
                GNT_ROT: begin
                    if (!rot_arb_req) grant <= GNT_IDLE;
                end
                default: grant <= GNT_IDLE;
            endcase
        end
    end

    assign load_arb_ack = (grant == GNT_LOAD);
    assign rot_arb_ack  = (grant == GNT_ROT);

    // The client without the grant sees a stalled port
    assign load_busy = load_arb_ack ? ddr_busy : 1'b1;
    assign rot_busy  = rot_arb_ack  ? ddr_busy : 1'b1;

    assign ddr_rd   = load_arb_ack && load_rd;
    assign ddr_we   = rot_arb_ack && rot_we;
    assign ddr_addr = load_arb_ack ? load_addr :
                      rot_arb_ack  ? rot_addr  : '0;
    assign ddr_din  = rot_arb_ack  ? rot_din   : '0;

    // Each client gives the port back after one accepted access
    ap_load_one_access: assert property (@(posedge clk_sys) disable iff (rst)
        ddr_rd && !ddr_busy |=> !load_arb_req);

    ap_rot_one_access: assert property (@(posedge clk_sys) disable iff (rst)
        ddr_we && !ddr_busy |=> !rot_arb_req);

endmodule

/* hdl/mr_ddr_bridge.sv */
// Top level: fast-load reader and rotation writer sharing one DDR port
`timescale 1ns/1ps
`include "mr_ddr_params.svh"

module mr_ddr_bridge (
    input  logic                   clk_sys,
    input  logic                   rst,
    // Load command and byte stream
    input  logic                   load_req,
    input  mr_ddr_pkg::ddr_addr_t  load_addr,
    input  logic [`LOAD_LEN_W-1:0] load_len,
    output logic                   load_ack,
    output logic                   ioctl_wr,
    output logic [26:0]            ioctl_addr,
    output logic [7:0]             ioctl_dout,
    // Pixel stream
    input  logic                   pix_valid,
    input  logic                   pix_sof,
    input  mr_ddr_pkg::pixel_t     pix_data,
    output logic                   pix_ready,
    // DDR port
    input  logic                   ddr_busy,
    output logic                   ddr_rd,
    output logic                   ddr_we,
    output mr_ddr_pkg::ddr_addr_t  ddr_addr,
    output mr_ddr_pkg::ddr_word_t  ddr_din,
    input  mr_ddr_pkg::ddr_word_t  ddr_dout,
    input  logic                   ddr_dout_ready
);

    // Loader to arbiter
    logic                  load_arb_req;
    logic                  load_arb_ack;
    logic                  load_rd;
    logic                  load_busy;
    mr_ddr_pkg::ddr_addr_t ld_ddr_addr;

    // Writer to arbiter
    logic                  rot_arb_req;
    logic                  rot_arb_ack;
    logic                  rot_we;
    logic                  rot_busy;
    mr_ddr_pkg::ddr_addr_t rot_ddr_addr;
    mr_ddr_pkg::ddr_word_t rot_din;

    ddr_load_reader u_load (
        .clk_sys    ( clk_sys        ),
        .rst        ( rst            ),
        .load_req   ( load_req       ),
        .load_addr  ( load_addr      ),
        .load_len   ( load_len       ),
        .load_ack   ( load_ack       ),
        .arb_req    ( load_arb_req   ),
        .arb_ack    ( load_arb_ack   ),
        .busy       ( load_busy      ),
        .rd         ( load_rd        ),
        .addr       ( ld_ddr_addr    ),
        .dout       ( ddr_dout       ),
        .dout_ready ( ddr_dout_ready ),
        .ioctl_wr   ( ioctl_wr       ),
        .ioctl_addr ( ioctl_addr     ),
        .ioctl_dout ( ioctl_dout     )
    );

    rot_line_writer u_rot (
        .clk_sys    ( clk_sys        ),
        .rst        ( rst            ),
        .pix_valid  ( pix_valid      ),
        .pix_sof    ( pix_sof        ),
        .pix_data   ( pix_data       ),
        .pix_ready  ( pix_ready      ),
        .arb_req    ( rot_arb_req    ),
        .arb_ack    ( rot_arb_ack    ),
        .busy       ( rot_busy       ),
        .we         ( rot_we         ),
        .addr       ( rot_ddr_addr   ),
        .din        ( rot_din        )
    );

    ddr_client_arbiter u_arb (
        .clk_sys      ( clk_sys      ),
        .rst          ( rst          ),
        .load_arb_req ( load_arb_req ),
        .load_arb_ack ( load_arb_ack ),
        .load_rd      ( load_rd      ),
        .load_addr    ( ld_ddr_addr  ),
        .load_busy    ( load_busy    ),
        .rot_arb_req  ( rot_arb_req  ),
        .rot_arb_ack  ( rot_arb_ack  ),
        .rot_we       ( rot_we       ),
        .rot_addr     ( rot_ddr_addr ),
        .rot_din      ( rot_din      ),
        .rot_busy     ( rot_busy     ),
        .ddr_busy     ( ddr_busy     ),
        .ddr_rd       ( ddr_rd       ),
        .ddr_we       ( ddr_we       ),
        .ddr_addr     ( ddr_addr     ),
        .ddr_din      ( ddr_din      )
    );

endmodule

/* test/ddr_model.sv */
// Behavioral DDR memory with external stall, variable read latency and write reports
`timescale 1ns/1ps
`include "mr_ddr_params.svh"

module ddr_model (
    input  logic                  clk_sys,
    input  logic                  rst,
    // Stall and latency picked by the testbench
    input  logic                  stall,
    input  logic [2:0]            lat,
    // DDR port
    output logic                  ddr_busy,
    input  logic                  ddr_rd,
    input  logic                  ddr_we,
    input  mr_ddr_pkg::ddr_addr_t ddr_addr,
    input  mr_ddr_pkg::ddr_word_t ddr_din,
    output mr_ddr_pkg::ddr_word_t ddr_dout,
    output logic                  ddr_dout_ready,
    // Preset content of the word being read
    output mr_ddr_pkg::ddr_addr_t rd_addr,
    input  logic [`DDR_DW-1:0]    fill_word,
    // One pulse per accepted write
    output logic                  wr_seen,
    output mr_ddr_pkg::ddr_addr_t wr_addr,
    output logic [`DDR_DW-1:0]    wr_data
);

    logic [`DDR_DW-1:0] mem [mr_ddr_pkg::ddr_addr_t];
    logic               rd_pending;
    logic [2:0]         wait_cnt;

    assign ddr_busy = stall;

    // Written words only, everything else reads as preset content
    always @(posedge clk_sys) begin
        if (!rst && ddr_we && !ddr_busy) begin
            mem[ddr_addr] = ddr_din;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            rd_pending     <= 1'b0;
            wait_cnt       <= 3'd0;
            rd_addr        <= '0;
            ddr_dout       <= '0;
            ddr_dout_ready <= 1'b0;
            wr_seen        <= 1'b0;
            wr_addr        <= '0;
            wr_data        <= '0;
        end else begin
            ddr_dout_ready <= 1'b0;
            wr_seen        <= 1'b0;
            if (ddr_rd && !ddr_busy) begin
                rd_pending <= 1'b1;
                rd_addr    <= ddr_addr;
                wait_cnt   <= lat;
            end else if (rd_pending) begin
                if (wait_cnt == 3'd0) begin
                    rd_pending     <= 1'b0;
                    ddr_dout_ready <= 1'b1;
                    ddr_dout       <= mem.exists(rd_addr) ? mem[rd_addr] : fill_word;
                end else begin
                    wait_cnt <= wait_cnt - 3'd1;
                end
            end
            if (ddr_we && !ddr_busy) begin
                wr_seen <= 1'b1;
                wr_addr <= ddr_addr;
                wr_data <= ddr_din;
            end
        end
    end

endmodule

/* test/tb_mr_ddr_bridge.sv */
// Testbench for the DDR bridge: stimulus, reference functions, checks and report
`timescale 1ns/1ps
`include "mr_ddr_params.svh"

module tb_mr_ddr_bridge;

    // Words loaded and pixels sent over all tests
    localparam int LOAD_WORDS     = 18;
    localparam int PIXELS         = 60;
    localparam int TIMEOUT_CYCLES = (LOAD_WORDS + PIXELS) * 64;

    logic                   clk_sys;
    logic                   rst;
    logic                   load_req;
    mr_ddr_pkg::ddr_addr_t  load_addr;
    logic [`LOAD_LEN_W-1:0] load_len;
    logic                   load_ack;
    logic                   ioctl_wr;
    logic [26:0]            ioctl_addr;
    logic [7:0]             ioctl_dout;
    logic                   pix_valid;
    logic                   pix_sof;
    mr_ddr_pkg::pixel_t     pix_data;
    logic                   pix_ready;
    logic                   ddr_busy;
    logic                   ddr_rd;
    logic                   ddr_we;
    mr_ddr_pkg::ddr_addr_t  ddr_addr;
    mr_ddr_pkg::ddr_word_t  ddr_din;
    mr_ddr_pkg::ddr_word_t  ddr_dout;
    logic                   ddr_dout_ready;

    logic                   stall;
    logic [2:0]             lat;
    logic                   hold_busy;
    mr_ddr_pkg::ddr_addr_t  rd_addr;
    logic [63:0]            fill_word;
    logic                   wr_seen;
    mr_ddr_pkg::ddr_addr_t  wr_addr;
    logic [63:0]            wr_data;

    // Expected writes, filled by the stimulus and consumed by the monitor
    mr_ddr_pkg::ddr_addr_t  exp_addr [0:31];
    logic [63:0]            exp_data [0:31];
    int                     wr_push;
    int                     wr_pop;
    mr_ddr_pkg::ddr_addr_t  next_addr;

    int          seq_errors;
    int          mon_errors;
    int          byte_cnt;
    int          bytes_total;
    int          rd_cycles;
    int          wr_count;
    int          pix_sent;
    int          cycles;
    logic [31:0] pix_state;
    logic [31:0] busy_state;

    mr_ddr_bridge u_dut (
        .clk_sys        ( clk_sys        ),
        .rst            ( rst            ),
        .load_req       ( load_req       ),
        .load_addr      ( load_addr      ),
        .load_len       ( load_len       ),
        .load_ack       ( load_ack       ),
        .ioctl_wr       ( ioctl_wr       ),
        .ioctl_addr     ( ioctl_addr     ),
        .ioctl_dout     ( ioctl_dout     ),
        .pix_valid      ( pix_valid      ),
        .pix_sof        ( pix_sof        ),
        .pix_data       ( pix_data       ),
        .pix_ready      ( pix_ready      ),
        .ddr_busy       ( ddr_busy       ),
        .ddr_rd         ( ddr_rd         ),
        .ddr_we         ( ddr_we         ),
        .ddr_addr       ( ddr_addr       ),
        .ddr_din        ( ddr_din        ),
        .ddr_dout       ( ddr_dout       ),
        .ddr_dout_ready ( ddr_dout_ready )
    );

    ddr_model u_mem (
        .clk_sys        ( clk_sys        ),
        .rst            ( rst            ),
        .stall          ( stall          ),
        .lat            ( lat            ),
        .ddr_busy       ( ddr_busy       ),
        .ddr_rd         ( ddr_rd         ),
        .ddr_we         ( ddr_we         ),
        .ddr_addr       ( ddr_addr       ),
        .ddr_din        ( ddr_din        ),
        .ddr_dout       ( ddr_dout       ),
        .ddr_dout_ready ( ddr_dout_ready ),
        .rd_addr        ( rd_addr        ),
        .fill_word      ( fill_word      ),
        .wr_seen        ( wr_seen        ),
        .wr_addr        ( wr_addr        ),
        .wr_data        ( wr_data        )
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Preset content, every bit pattern tied to the full address
    function automatic logic [63:0] mem_word(input mr_ddr_pkg::ddr_addr_t a);
        return {a, 3'b101, a ^ 29'h0c81c3a5, 3'b010};
    endfunction

    // Byte idx of a load from base, low byte of each word first
    function automatic logic [7:0] exp_byte(input mr_ddr_pkg::ddr_addr_t base, input int idx);
        logic [63:0] w;
        w = mem_word(base + 29'(idx / 8));
        return w[8 * (idx % 8) +: 8];
    endfunction

    // First pixel in the low bits
    function automatic logic [63:0] pack_word(input logic [15:0] p0, input logic [15:0] p1,
                                              input logic [15:0] p2, input logic [15:0] p3);
        return {p3, p2, p1, p0};
    endfunction

    assign fill_word = mem_word(rd_addr);

    task automatic value_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] exp);
        $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
    endtask

    initial begin
        clk_sys = 1'b0;
        forever #4 clk_sys = ~clk_sys;
    end

    // Random stall and latency, about one busy cycle in four
    initial begin
        busy_state = 32'hc81c;
        stall      = 1'b0;
        lat        = 3'd0;
        forever begin
            @(negedge clk_sys);
            busy_state = lcg_step(busy_state);
            stall      = hold_busy | (busy_state[31:30] == 2'b00);
            lat        = busy_state[18:16];
        end
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_sys);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    // Compare bytes and writes against the reference
    always @(negedge clk_sys) begin
        if (!rst) begin
            if (ddr_rd && ddr_we) begin
                mon_errors++;
                $display("ddr_rd and ddr_we both high at %0t", $time);
            end
            if (ddr_rd) rd_cycles++;
            if (!load_req) byte_cnt = 0;
            if (ioctl_wr) begin
                if (!load_req) begin
                    mon_errors++;
                    $display("ioctl_wr pulsed with no load running at %0t", $time);
                end
                if (ioctl_addr != 27'(byte_cnt)) begin
                    mon_errors++;
                    value_mismatch("ioctl_addr", 64'(ioctl_addr), 64'(byte_cnt));
                end
                if (ioctl_dout != exp_byte(load_addr, byte_cnt)) begin
                    mon_errors++;
                    value_mismatch("ioctl_dout", 64'(ioctl_dout),
                                   64'(exp_byte(load_addr, byte_cnt)));
                end
                byte_cnt++;
                bytes_total++;
            end
            if (wr_seen) begin
                if (wr_pop >= wr_push) begin
                    mon_errors++;
                    $display("Unexpected DDR write to %h at %0t", wr_addr, $time);
                end else begin
                    if (wr_addr != exp_addr[wr_pop]) begin
                        mon_errors++;
                        value_mismatch("ddr_addr", 64'(wr_addr), 64'(exp_addr[wr_pop]));
                    end
                    if (wr_data != exp_data[wr_pop]) begin
                        mon_errors++;
                        value_mismatch("ddr_din", wr_data, exp_data[wr_pop]);
                    end
                    wr_pop++;
                end
                wr_count++;
            end
        end
    end

    task automatic run_load(input mr_ddr_pkg::ddr_addr_t addr, input int len);
        int rd_before;
        @(negedge clk_sys);
        rd_before = rd_cycles;
        load_addr = addr;
        load_len  = 16'(len);
        load_req  = 1'b1;
        while (!load_ack) @(negedge clk_sys);
        if (byte_cnt != 8 * len) begin
            seq_errors++;
            $display("Load from %h ended after %0d bytes, expected %0d", addr, byte_cnt, 8 * len);
        end
        if (len == 0 && rd_cycles != rd_before) begin
            seq_errors++;
            $display("Empty load issued a DDR read");
        end
        load_req = 1'b0;
        @(negedge clk_sys);
        if (load_ack) begin
            seq_errors++;
            $display("load_ack still high a cycle after load_req dropped at %0t", $time);
        end
    endtask

    // Groups of four pixels, the first one flagged as start of frame
    task automatic send_groups(input int groups, input logic with_sof);
        logic [15:0] px [0:3];
        logic        ready_seen;
        int          g;
        int          k;
        if (with_sof) next_addr = `ROT_BASE;
        for (g = 0; g < groups; g++) begin
            for (k = 0; k < 4; k++) begin
                @(negedge clk_sys);
                pix_state = lcg_step(pix_state);
                px[k]     = pix_state[31:16];
                pix_valid = 1'b1;
                pix_sof   = with_sof && (g == 0) && (k == 0);
                pix_data  = px[k];
                ready_seen = pix_ready;
                while (!ready_seen) begin
                    @(negedge clk_sys);
                    ready_seen = pix_ready;
                end
                pix_sent++;
            end
            exp_addr[wr_push] = next_addr;
            exp_data[wr_push] = pack_word(px[0], px[1], px[2], px[3]);
            wr_push++;
            next_addr = next_addr + 29'd1;
        end
        @(negedge clk_sys);
        pix_valid = 1'b0;
        pix_sof   = 1'b0;
    endtask

    task automatic wait_writes();
        while (wr_pop != wr_push) @(negedge clk_sys);
    endtask

    initial begin
        rst         = 1'b1;
        load_req    = 1'b0;
        load_addr   = '0;
        load_len    = '0;
        pix_valid   = 1'b0;
        pix_sof     = 1'b0;
        pix_data    = '0;
        hold_busy   = 1'b0;
        pix_state   = 32'hc81c;
        next_addr   = `ROT_BASE;
        wr_push     = 0;
        seq_errors  = 0;
        pix_sent    = 0;
        repeat (16) @(negedge clk_sys);
        rst = 1'b0;

        // Idle outputs after reset
        @(negedge clk_sys);
        if (ddr_rd || ddr_we || ioctl_wr || load_ack || !pix_ready) begin
            seq_errors++;
            $display("Outputs not in their idle state after reset");
        end

        run_load(29'h0000040, 3);
        run_load(29'h1abcde0, 5);

        // Frame restart goes back to the base address
        send_groups(3, 1'b1);
        send_groups(2, 1'b1);
        wait_writes();

        fork
            begin
                run_load(29'h0002000, 4);
                run_load(29'h0fffffc, 6);
            end
            send_groups(8, 1'b1);
        join
        wait_writes();

        // Long busy stretch holds the writer
        hold_busy = 1'b1;
        fork
            send_groups(2, 1'b1);
            begin
                repeat (40) @(negedge clk_sys);
                if (pix_ready) begin
                    seq_errors++;
                    $display("pix_ready stayed high while a word waited on DDR busy");
                end
                hold_busy = 1'b0;
            end
        join
        wait_writes();

        run_load(29'h0000200, 0);

        if (wr_count != pix_sent / 4) begin
            seq_errors++;
            $display("%0d words written for %0d pixels sent", wr_count, pix_sent);
        end

        $display("Bytes checked %0d, words written %0d, errors %0d",
                 bytes_total, wr_count, seq_errors + mon_errors);
        if (seq_errors + mon_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        mon_errors  = 0;
        byte_cnt    = 0;
        bytes_total = 0;
        rd_cycles   = 0;
        wr_count    = 0;
        wr_pop      = 0;
    end

endmodule

/* mr_ddr_bridge.f */
+incdir+include
hdl/mr_ddr_pkg.sv
hdl/ddr_load_reader.sv
hdl/rot_line_writer.sv
hdl/ddr_client_arbiter.sv
hdl/mr_ddr_bridge.sv
test/ddr_model.sv
test/tb_mr_ddr_bridge.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_mr_ddr_bridge \
    -f mr_ddr_bridge.f \
    --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "^Finished with no errors$" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
